// ==== files.f ====
design/detectorPkg.sv
design/triggerPkg.sv
design/layerSummaryIf.sv
design/hitConditioner.sv
design/layerCounter.sv
design/triggerDecision.sv
design/eventRecorder.sv
design/triggerTop.sv
test/triggerTopTb.sv

// ==== Bender.yml ====
package:
  name: scintTrigger

sources:
  - design/detectorPkg.sv
  - design/triggerPkg.sv
  - design/layerSummaryIf.sv
  - design/hitConditioner.sv
  - design/layerCounter.sv
  - design/triggerDecision.sv
  - design/eventRecorder.sv
  - design/triggerTop.sv
  - target: test
    files:
      - test/triggerTopTb.sv

// ==== test/triggerTopTb.sv ====
`timescale 1ns/1ps

module triggerTopTb;
	import detectorPkg::*;
	import triggerPkg::*;

	localparam int halfPeriod = 4; // 8 ns clk_adc
	localparam int resetCycles = 10;
	localparam int numThresholdEvents = 6;
	localparam int quietCycles = 40; // covers hold, pipeline and dead time of one hit
	localparam int recordWait = 60; // hit to commit is about 25 cycles
	// rough budget per test, the watchdog allows twice the sum
	localparam int plannedCycles = resetCycles + 10 + 60 + numThresholdEvents * 60
		+ 4 * 50 + 200 + 60;
	localparam logic [numBars-1:0] fourBars = 32'h0808_0808; // column 3 in every layer

	logic clk_adc = 1'b0;
	logic resetClock2;
	logic [numBars-1:0] barLines;
	logic [numAuxLines-1:0] auxLines;
	logic [numLines-1:0] channelMask;
	logic armed;
	triggerVec triggerEnable;
	holdType coincidenceTime;
	deadType deadTime;
	logic [31:0] prescale;
	logic [31:0] randNum = '0; // only the random driver writes it
	logic [7:0] nLayerThreshold;
	logic [7:0] nHitThreshold;
	logic syncHold;
	logic clearRecords;
	recordIndex recordSelect;
	logic triggerOut;
	recordIndex recordCount;
	triggerVec recordBits;
	timestampType recordTime;

	integer seed = 32'hd91c; // randNum stream
	integer patternSeed = 32'hd91c; // hit patterns and thresholds
	logic forceRand = 1'b0; // randNum never zero while set
	logic expectQuiet = 1'b0; // triggerOut must stay low while set
	logic [63:0] cycleCount; // runs like the DUT timestamp until a clear
	recordIndex expCount = '0; // records the testbench expects so far
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	triggerTop UUT (
		.clk_adc         (clk_adc),
		.resetClock2     (resetClock2),
		.barLines        (barLines),
		.auxLines        (auxLines),
		.channelMask     (channelMask),
		.armed           (armed),
		.triggerEnable   (triggerEnable),
		.coincidenceTime (coincidenceTime),
		.deadTime        (deadTime),
		.prescale        (prescale),
		.randNum         (randNum),
		.nLayerThreshold (nLayerThreshold),
		.nHitThreshold   (nHitThreshold),
		.syncHold        (syncHold),
		.clearRecords    (clearRecords),
		.recordSelect    (recordSelect),
		.triggerOut      (triggerOut),
		.recordCount     (recordCount),
		.recordBits      (recordBits),
		.recordTime      (recordTime)
	);

	always #halfPeriod clk_adc = ~clk_adc;

	always @(posedge clk_adc) begin
		if (resetClock2) cycleCount <= '0;
		else cycleCount <= cycleCount + 1'b1;
	end

	always @(negedge clk_adc) begin // fresh random value each cycle
		if (forceRand) randNum = $random(seed) | 32'h1;
		else randNum = $random(seed);
	end

	//////////////////////////////
	// report helpers
	//////////////////////////////

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task automatic endTest(input string name, input int errorsBefore);
		testsRun++;
		if (errorCount == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	//////////////////////////////
	// concurrent checks
	//////////////////////////////

	assert property (@(posedge clk_adc) resetClock2 |=> (!triggerOut && recordCount == '0))
		else reportMismatch("outputs not cleared by reset");

	assert property (@(posedge clk_adc) disable iff (resetClock2) expectQuiet |-> !triggerOut)
		else reportMismatch("triggerOut pulsed while the trigger was gated");

	// count moves by one slot or back to zero on a clear
	assert property (@(posedge clk_adc) disable iff (resetClock2)
		!$stable(recordCount) |->
		(recordCount == recordIndex'($past(recordCount) + 1'b1)) || $past(clearRecords))
		else reportMismatch("recordCount jumped");

	assert property (@(posedge clk_adc) disable iff (resetClock2)
		(syncHold && !clearRecords) |=> $stable(recordCount))
		else reportMismatch("record committed while syncHold was high");

	//////////////////////////////
	// stimulus and reference rules
	//////////////////////////////

	// lines low for one cycle, hitCycle is the own count just after the sampling edge
	task automatic pulseHits(input logic [numBars-1:0] bars, input logic [1:0] aux,
		output logic [63:0] hitCycle);
		@(negedge clk_adc);
		barLines = ~bars; // active low
		auxLines = ~aux;
		@(negedge clk_adc);
		barLines = '1;
		auxLines = '1;
		hitCycle = cycleCount;
	endtask

	function automatic int countLayers(input logic [numBars-1:0] bars);
		int layers = 0;
		for (int l = 0; l < numLayers; l++) begin
			if (bars[l*barsPerLayer +: barsPerLayer] != '0) layers++;
		end
		return layers;
	endfunction

	// nLayers is at or above, gtNHits strictly above
	function automatic triggerVec thresholdBits(input logic [numBars-1:0] bars,
		input logic [7:0] layerThr, input logic [7:0] hitThr);
		triggerVec bits = '0;
		bits[nLayers] = countLayers(bars) >= int'(layerThr);
		bits[gtNHits] = $countones(bars) > int'(hitThr);
		return bits;
	endfunction

	// wait for the next commit with a timeout, then read the slot back
	task automatic expectRecord(input triggerVec expBits, input string label);
		recordIndex slot;
		bit seen;
		slot = expCount;
		seen = 1'b0;
		for (int k = 0; k < recordWait && !seen; k++) begin
			@(negedge clk_adc);
			seen = recordCount == recordIndex'(slot + 1'b1);
		end
		if (!seen) begin
			reportProblem($sformatf("%s: no record committed within %0d cycles",
				label, recordWait));
			expCount = recordCount; // resync for later tests
		end else begin
			expCount = recordIndex'(slot + 1'b1);
			recordSelect = slot;
			@(negedge clk_adc); // read port is combinational
			assert (recordBits === expBits) else reportMismatch($sformatf(
				"%s: slot %0d bits %h, expected %h", label, slot, recordBits, expBits));
		end
	endtask

	initial begin // watchdog
		#(plannedCycles * 2 * 2 * halfPeriod);
		$display("watchdog: run timed out after %0d cycles", plannedCycles * 2);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int errorsBefore;
		int riseDelay;
		int highTime;
		logic [63:0] hitCycle;
		logic [63:0] fireCycle;
		logic [numBars-1:0] bars;
		logic [numLayers-1:0] layerPick;
		triggerVec expBits;

		resetClock2 = 1'b1;
		barLines = '1; // idle lines are high
		auxLines = '1;
		channelMask = '1;
		armed = 1'b1;
		triggerEnable = '0;
		coincidenceTime = 6'd10;
		deadTime = 8'd20;
		prescale = '1; // always passes
		nLayerThreshold = 8'd4;
		nHitThreshold = 8'd31;
		syncHold = 1'b0;
		clearRecords = 1'b0;
		recordSelect = '0;
		repeat (resetCycles) @(negedge clk_adc);
		resetClock2 = 1'b0;

		// reset state, quiet until the first hit
		errorsBefore = errorCount;
		repeat (5) begin
			@(negedge clk_adc);
			assert (!triggerOut && recordCount == '0) else reportMismatch($sformatf(
				"after reset triggerOut %b recordCount %0d", triggerOut, recordCount));
		end
		endTest("reset state", errorsBefore);

		// single fourLayers trigger
		errorsBefore = errorCount;
		triggerEnable = 8'h01;
		pulseHits(fourBars, 2'b00, hitCycle);
		riseDelay = 0;
		fireCycle = '0;
		while (!triggerOut && riseDelay < 30) begin
			@(negedge clk_adc);
			riseDelay++;
			if (riseDelay == 4) fireCycle = cycleCount; // own count after E+4
		end
		assert (riseDelay == 5) else reportMismatch($sformatf(
			"triggerOut rose %0d cycles after the hit, expected 5", riseDelay));
		highTime = 0;
		while (triggerOut && highTime < 40) begin
			highTime++;
			@(negedge clk_adc);
		end
		assert (highTime == pulseLength) else reportMismatch($sformatf(
			"pulse %0d cycles long, expected %0d", highTime, pulseLength));
		expectRecord(8'h01, "single trigger");
		assert (recordTime >= hitCycle && recordTime <= fireCycle) else reportMismatch(
			$sformatf("timestamp %0d outside %0d to %0d", recordTime, hitCycle, fireCycle));
		endTest("single trigger", errorsBefore);

		// threshold triggers on random patterns
		errorsBefore = errorCount;
		triggerEnable = 8'h50; // nLayers and gtNHits
		for (int ev = 0; ev < numThresholdEvents; ev++) begin
			layerPick = $random(patternSeed);
			bars = $random(patternSeed) & $random(patternSeed); // sparse
			for (int l = 0; l < numLayers; l++) begin
				if (!layerPick[l]) bars[l*barsPerLayer +: barsPerLayer] = '0;
			end
			@(negedge clk_adc);
			nLayerThreshold = 8'(1 + {$random(patternSeed)} % 4);
			nHitThreshold = 8'({$random(patternSeed)} % 7);
			if (ev == 0) begin // near miss on both thresholds, two bars in two layers
				bars = 32'h0000_0101;
				nLayerThreshold = 8'd3;
				nHitThreshold = 8'd2;
			end
			expBits = thresholdBits(bars, nLayerThreshold, nHitThreshold);
			if (expBits == '0) begin
				expectQuiet = 1'b1;
				pulseHits(bars, 2'b00, hitCycle);
				repeat (quietCycles) @(negedge clk_adc);
				expectQuiet = 1'b0;
				assert (recordCount == expCount) else reportMismatch($sformatf(
					"bars %h made a record with no condition met", bars));
			end else begin
				pulseHits(bars, 2'b00, hitCycle);
				expectRecord(expBits, $sformatf("threshold event %0d", ev));
			end
		end
		nLayerThreshold = 8'd4;
		nHitThreshold = 8'd31;
		endTest("threshold triggers", errorsBefore);

		// gating: armed, mask, enable, prescale
		errorsBefore = errorCount;
		triggerEnable = 8'h01;
		for (int gate = 0; gate < 4; gate++) begin
			@(negedge clk_adc);
			case (gate)
				0: armed = 1'b0;
				1: channelMask = ~{2'b00, fourBars};
				2: triggerEnable = '0;
				default: begin
					prescale = '0;
					forceRand = 1'b1;
				end
			endcase
			expectQuiet = 1'b1;
			pulseHits(fourBars, 2'b00, hitCycle);
			repeat (quietCycles) @(negedge clk_adc);
			expectQuiet = 1'b0;
			assert (recordCount == expCount) else reportMismatch($sformatf(
				"gating case %0d: recordCount %0d, expected %0d", gate, recordCount, expCount));
			armed = 1'b1;
			channelMask = '1;
			triggerEnable = 8'h01;
			prescale = '1;
			forceRand = 1'b0;
		end
		endTest("gating", errorsBefore);

		// dead time, merging, syncHold, aux lines
		errorsBefore = errorCount;
		triggerEnable = '1;
		pulseHits(32'h0000_0101, 2'b00, hitCycle); // layers 0 and 1 give adjacent
		repeat (11) @(negedge clk_adc); // first hit gone, adjacent still dead
		pulseHits(32'h0020_0020, 2'b00, hitCycle); // layers 0 and 2 give separated
		expectRecord(8'h0C, "merged hits");
		repeat (30) @(negedge clk_adc); // all dead timers run out
		syncHold = 1'b1;
		pulseHits(32'h0000_0101, 2'b00, hitCycle);
		repeat (quietCycles) @(negedge clk_adc);
		assert (recordCount == expCount) else reportMismatch("record not held by syncHold");
		syncHold = 1'b0;
		expectRecord(8'h08, "held record");
		repeat (5) @(negedge clk_adc);
		pulseHits('0, 2'b01, hitCycle);
		expectRecord(8'h20, "external line");
		repeat (5) @(negedge clk_adc);
		pulseHits('0, 2'b10, hitCycle);
		expectRecord(8'h80, "internal line");
		endTest("dead time and merging", errorsBefore);

		// clearing
		errorsBefore = errorCount;
		@(negedge clk_adc);
		triggerEnable = 8'h02; // threeInRow, bits no earlier record carries
		clearRecords = 1'b1;
		@(negedge clk_adc);
		clearRecords = 1'b0;
		assert (recordCount == '0) else reportMismatch($sformatf(
			"recordCount %0d after clear", recordCount));
		expCount = '0;
		pulseHits(fourBars, 2'b00, hitCycle);
		expectRecord(8'h02, "after clear"); // lands in slot 0
		endTest("clearing", errorsBefore);

		$display("tests run %0d, tests failed %0d, errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== design/triggerTop.sv ====
`timescale 1ns/1ps

module triggerTop (
	input  logic                               clk_adc,
	input  logic                               resetClock2,
	input  logic [detectorPkg::numBars-1:0]     barLines,
	input  logic [detectorPkg::numAuxLines-1:0] auxLines,
	input  logic [detectorPkg::numLines-1:0]    channelMask,
	input  logic                               armed,
	input  triggerPkg::triggerVec              triggerEnable,
	input  detectorPkg::holdType               coincidenceTime,
	input  triggerPkg::deadType                deadTime,
	input  logic [31:0]                        prescale,
	input  logic [31:0]                        randNum,
	input  logic [7:0]                         nLayerThreshold,
	input  logic [7:0]                         nHitThreshold,
	input  logic                               syncHold,
	input  logic                               clearRecords,
	input  triggerPkg::recordIndex             recordSelect,
	output logic                               triggerOut,
	output triggerPkg::recordIndex             recordCount,
	output triggerPkg::triggerVec              recordBits,
	output triggerPkg::timestampType           recordTime
);
	import detectorPkg::*;
	import triggerPkg::*;

	logic [numLines-1:0] activeLines; // stretched hits, E+1
	triggerVec fireStrobe;
	triggerVec deadActive;

	layerSummaryIf summaryBus (); // counter to decision, E+3

	//////////////////////////////
	// pipeline
	//////////////////////////////

	hitConditioner uHitConditioner (
		.clk_adc         (clk_adc),
		.resetClock2     (resetClock2),
		.barLines        (barLines),
		.auxLines        (auxLines),
		.channelMask     (channelMask),
		.coincidenceTime (coincidenceTime),
		.activeLines     (activeLines)
	);

	layerCounter uLayerCounter (
		.clk_adc     (clk_adc),
		.resetClock2 (resetClock2),
		.activeLines (activeLines),
		.summary     (summaryBus.source)
	);

	triggerDecision uTriggerDecision (
		.clk_adc         (clk_adc),
		.resetClock2     (resetClock2),
		.summary         (summaryBus.sink),
		.triggerEnable   (triggerEnable),
		.armed           (armed),
		.prescale        (prescale),
		.randNum         (randNum),
		.nLayerThreshold (nLayerThreshold),
		.nHitThreshold   (nHitThreshold),
		.deadTime        (deadTime),
		.fireStrobe      (fireStrobe),
		.deadActive      (deadActive),
		.triggerOut      (triggerOut)
	);

	eventRecorder uEventRecorder (
		.clk_adc      (clk_adc),
		.resetClock2  (resetClock2),
		.fireStrobe   (fireStrobe),
		.deadActive   (deadActive),
		.syncHold     (syncHold),
		.clearRecords (clearRecords),
		.recordSelect (recordSelect),
		.recordCount  (recordCount),
		.recordBits   (recordBits),
		.recordTime   (recordTime)
	);

endmodule

// ==== design/eventRecorder.sv ====
`timescale 1ns/1ps

module eventRecorder (
	input  logic                   clk_adc,
	input  logic                   resetClock2,
	input  triggerPkg::triggerVec  fireStrobe,
	input  triggerPkg::triggerVec  deadActive,
	input  logic                   syncHold, // holds the commit while high
	input  logic                   clearRecords,
	input  triggerPkg::recordIndex recordSelect,
	output triggerPkg::recordIndex recordCount, // next slot to write
	output triggerPkg::triggerVec  recordBits,
	output triggerPkg::timestampType recordTime
);
	import triggerPkg::*;

	typedef enum logic {recIdle, recOpen} recState;

	recState state;
	timestampType timestamp; // free running clk_adc count
	triggerId lowestFired;
	triggerId firstTrig; // decides when the record closes
	triggerVec openBits; // bitstring collected so far
	timestampType openTime;
	logic commit;

	triggerVec bitsMem [recordDepth];
	timestampType timeMem [recordDepth];

	// lowest index wins when several fire together
	always_comb begin
		lowestFired = fourLayers;
		for (int n = numTriggers - 1; n >= 0; n--) begin
			if (fireStrobe[n]) lowestFired = triggerId'(n);
		end
	end

	assign commit = (state == recOpen) && !deadActive[firstTrig] && !syncHold;

	//////////////////////////////
	// open record FSM
	//////////////////////////////

	always_ff @(posedge clk_adc) begin
		if (resetClock2 || clearRecords) begin
			timestamp <= '0;
			state <= recIdle;
			recordCount <= '0;
		end else begin
			timestamp <= timestamp + 1'b1;
			case (state)
				recIdle: begin
					if (|fireStrobe) begin
						state <= recOpen;
						firstTrig <= lowestFired;
						openBits <= fireStrobe;
						openTime <= timestamp; // time of the first fire
					end
				end
				recOpen: begin
					if (commit) begin
						state <= recIdle;
						recordCount <= recordCount + 1'b1; // wraps after slot 7
					end else begin
						openBits <= openBits | fireStrobe; // merge later fires
					end
				end
				default: state <= recIdle;
			endcase
		end
	end

	// fires landing on the commit edge still go into this record
	always_ff @(posedge clk_adc) begin
		if (commit) begin
			bitsMem[recordCount] <= openBits | fireStrobe;
			timeMem[recordCount] <= openTime;
		end
	end

	assign recordBits = bitsMem[recordSelect];
	assign recordTime = timeMem[recordSelect];

endmodule

// ==== design/triggerDecision.sv ====
`timescale 1ns/1ps

module triggerDecision (
	input  logic                clk_adc,
	input  logic                resetClock2,
	layerSummaryIf.sink         summary,
	input  triggerPkg::triggerVec triggerEnable,
	input  logic                armed, // run level, low blocks every trigger
	input  logic [31:0]         prescale,
	input  logic [31:0]         randNum,
	input  logic [7:0]          nLayerThreshold,
	input  logic [7:0]          nHitThreshold,
	input  triggerPkg::deadType deadTime, // at least 1
	output triggerPkg::triggerVec fireStrobe,
	output triggerPkg::triggerVec deadActive,
	output logic                triggerOut
);
	import detectorPkg::*;
	import triggerPkg::*;

	logic passPrescale; // registered at E+3
	triggerVec condition;
	triggerVec fireNow; // decision for the coming edge
	deadType deadTimer [numTriggers];
	logic [pulseWidth-1:0] pulseCount;

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			passPrescale <= 1'b0;
		end else begin
			passPrescale <= randNum <= prescale; // prescale all ones always passes
		end
	end

	//////////////////////////////
	// trigger conditions
	//////////////////////////////

	always_comb begin
		condition = '0;
		condition[fourLayers] = summary.layersHit == numLayers;
		condition[threeInRow] = summary.rowTriple;
		condition[separatedLayers] = summary.separatedHit;
		condition[adjacentLayers] = summary.adjacentHit;
		condition[nLayers] = summary.layersHit >= nLayerThreshold;
		condition[external] = summary.externalHit; // own aux line
		condition[gtNHits] = summary.barCount > nHitThreshold; // strictly above
		condition[internal] = summary.internalHit;
	end

	// enable, not dead, armed, prescale and the condition itself
	always_comb begin
		for (int n = 0; n < numTriggers; n++) begin
			deadActive[n] = deadTimer[n] != '0;
			fireNow[n] = triggerEnable[n] & ~deadActive[n] & armed & passPrescale & condition[n];
		end
	end

	//////////////////////////////
	// dead timers and pulse
	//////////////////////////////

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			fireStrobe <= '0;
			for (int n = 0; n < numTriggers; n++) deadTimer[n] <= '0;
			pulseCount <= '0;
			triggerOut <= 1'b0;
		end else begin
			fireStrobe <= fireNow; // one cycle per fire
			for (int n = 0; n < numTriggers; n++) begin
				if (fireNow[n]) begin
					deadTimer[n] <= deadTime;
				end else if (deadActive[n]) begin
					deadTimer[n] <= deadTimer[n] - 1'b1;
				end
			end
			// a fire only starts the pulse if nothing was dead before this edge
			if ((|fireNow) && !(|deadActive)) begin
				pulseCount <= pulseWidth'(pulseLength);
			end else if (pulseCount != '0) begin
				pulseCount <= pulseCount - 1'b1;
			end
			triggerOut <= pulseCount != '0; // one stage late, high from E+5
		end
	end

endmodule

// ==== design/layerCounter.sv ====
`timescale 1ns/1ps

module layerCounter (
	input logic                            clk_adc,
	input logic                            resetClock2,
	input logic [detectorPkg::numLines-1:0] activeLines,
	layerSummaryIf.source                  summary
);
	import detectorPkg::*;

	countType layerNext [numLayers];
	countType columnNext [barsPerLayer];
	countType layerCount [numLayers]; // active bars per layer, E+2
	countType columnCount [barsPerLayer]; // active layers per column, E+2
	logic [numAuxLines-1:0] auxStage; // aux bits in step with the counts

	logic [numLayers-1:0] layerHit;
	countType layersNext;
	countType barsNext;
	logic tripleNext;

	//////////////////////////////
	// stage 1 counts
	//////////////////////////////

	always_comb begin
		for (int l = 0; l < numLayers; l++) begin
			layerNext[l] = '0;
			for (int c = 0; c < barsPerLayer; c++) begin
				layerNext[l] = layerNext[l] + countType'(activeLines[l*barsPerLayer + c]);
			end
		end
		// same bars, summed down each column
		for (int c = 0; c < barsPerLayer; c++) begin
			columnNext[c] = '0;
			for (int l = 0; l < numLayers; l++) begin
				columnNext[c] = columnNext[c] + countType'(activeLines[l*barsPerLayer + c]);
			end
		end
	end

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			for (int l = 0; l < numLayers; l++) layerCount[l] <= '0;
			for (int c = 0; c < barsPerLayer; c++) columnCount[c] <= '0;
			auxStage <= '0;
		end else begin
			layerCount <= layerNext;
			columnCount <= columnNext;
			auxStage <= activeLines[numLines-1:numBars]; // external, internal
		end
	end

	//////////////////////////////
	// stage 2 flags
	//////////////////////////////

	always_comb begin
		layersNext = '0;
		barsNext = '0;
		tripleNext = 1'b0;
		for (int l = 0; l < numLayers; l++) begin
			layerHit[l] = layerCount[l] != '0;
			layersNext = layersNext + countType'(layerHit[l]);
			barsNext = barsNext + layerCount[l];
		end
		for (int c = 0; c < barsPerLayer; c++) begin
			tripleNext = tripleNext | (columnCount[c] >= 3); // 3 of 4 layers in one column
		end
	end

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			summary.layersHit <= '0;
			summary.barCount <= '0;
			summary.rowTriple <= 1'b0;
			summary.separatedHit <= 1'b0;
			summary.adjacentHit <= 1'b0;
			summary.externalHit <= 1'b0;
			summary.internalHit <= 1'b0;
		end else begin
			summary.layersHit <= layersNext;
			summary.barCount <= barsNext;
			summary.rowTriple <= tripleNext;
			summary.separatedHit <= (layerHit[0] & layerHit[2]) | (layerHit[1] & layerHit[3]);
			summary.adjacentHit <= |(layerHit[numLayers-2:0] & layerHit[numLayers-1:1]);
			summary.externalHit <= auxStage[0]; // lands at E+3 like the bar flags
			summary.internalHit <= auxStage[1];
		end
	end

endmodule

// ==== design/hitConditioner.sv ====
`timescale 1ns/1ps

module hitConditioner (
	input  logic                               clk_adc,
	input  logic                               resetClock2,
	input  logic [detectorPkg::numBars-1:0]     barLines, // active low
	input  logic [detectorPkg::numAuxLines-1:0] auxLines, // active low
	input  logic [detectorPkg::numLines-1:0]    channelMask, // 1 keeps the channel
	input  detectorPkg::holdType                coincidenceTime,
	output logic [detectorPkg::numLines-1:0]    activeLines
);
	import detectorPkg::*;

	logic [numLines-1:0] rawLines; // bars low, aux on top
	logic [numLines-1:0] hitReg; // inverted and masked, sampled at E
	holdType holdTimer [numLines];

	assign rawLines = {auxLines, barLines};

	// invert so a floating or unplugged input reads as no hit
	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			hitReg <= '0;
		end else begin
			hitReg <= ~rawLines & channelMask; // masked lines forced to 0
		end
	end

	//////////////////////////////
	// stretch each hit
	//////////////////////////////

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			for (int i = 0; i < numLines; i++) begin
				holdTimer[i] <= '0;
			end
		end else begin
			for (int i = 0; i < numLines; i++) begin
				if (hitReg[i]) begin
					holdTimer[i] <= coincidenceTime; // reload while the line stays low
				end else if (holdTimer[i] != '0) begin
					holdTimer[i] <= holdTimer[i] - 1'b1; // release, count down
				end
			end
		end
	end

	// active from E+1 on, for coincidenceTime - activeMin cycles after release
	always_comb begin
		for (int i = 0; i < numLines; i++) begin
			activeLines[i] = holdTimer[i] > activeMin;
		end
	end

endmodule

// ==== design/layerSummaryIf.sv ====
`timescale 1ns/1ps

// summary flags from the counter stage, all registered at E+3
interface layerSummaryIf;
	import detectorPkg::*;

	countType layersHit; // layers with at least one active bar
	countType barCount; // active bars summed over all layers
	logic rowTriple; // some column active in three layers or more
	logic separatedHit; // layers 0 and 2, or layers 1 and 3
	logic adjacentHit; // any neighbouring pair of layers
	logic externalHit; // aux line 0, stretched and delayed
	logic internalHit; // aux line 1

	modport source (
		output layersHit, barCount, rowTriple, separatedHit, adjacentHit,
		output externalHit, internalHit
	);
	modport sink (
		input layersHit, barCount, rowTriple, separatedHit, adjacentHit,
		input externalHit, internalHit
	);

endinterface

// ==== design/triggerPkg.sv ====
package triggerPkg;

	//////////////////////////////
	// trigger bits
	//////////////////////////////

	// bit positions in the trigger vector and in the record bitstring
	typedef enum logic [2:0] {
		fourLayers, // a hit in every layer
		threeInRow, // one column hit in three layers or more
		separatedLayers, // two non neighbouring layers
		adjacentLayers, // two neighbouring layers
		nLayers, // layer count at or above threshold
		external, // external trigger line
		gtNHits, // bar count above threshold
		internal // digitizer internal trigger
	} triggerId;

	localparam int numTriggers = 8;
	typedef logic [numTriggers-1:0] triggerVec; // one bit per triggerId

	//////////////////////////////
	// dead time and output pulse
	//////////////////////////////

	localparam int deadWidth = 8;
	typedef logic [deadWidth-1:0] deadType; // per trigger dead timer

	localparam int pulseLength = 16; // triggerOut high time in cycles
	localparam int pulseWidth = $clog2(pulseLength + 1); // counter must hold pulseLength

	//////////////////////////////
	// event records
	//////////////////////////////

	localparam int timestampWidth = 56;
	typedef logic [timestampWidth-1:0] timestampType; // clk_adc cycles since reset or clear

	localparam int recordDepth = 8;
	typedef logic [$clog2(recordDepth)-1:0] recordIndex; // slot number, wraps at 8

endpackage

// ==== design/detectorPkg.sv ====
package detectorPkg;

	//////////////////////////////
	// detector geometry
	//////////////////////////////

	localparam int numLayers = 4; // bar layers, stacked
	localparam int barsPerLayer = 8; // one bar per column in every layer
	localparam int numBars = numLayers * barsPerLayer; // bar index is layer*8 + column
	localparam int numAuxLines = 2; // 0 is the external line, 1 the digitizer internal line
	localparam int numLines = numBars + numAuxLines; // aux lines sit above the bars

	//////////////////////////////
	// hit timing
	//////////////////////////////

	localparam int holdWidth = 6; // hold timer bits, same as coincidenceTime
	// a channel reads active only while its timer is above this,
	// so the stretched hit drops out a little before the dead logic clears
	localparam int activeMin = 2;

	typedef logic [holdWidth-1:0] holdType; // per channel stretch timer
	typedef logic [6:0] countType; // bar and layer counts, max 32 fits

endpackage
